// File: core.f
src/core_cfg_pkg.sv
src/isa_pkg.sv
src/alu.sv
src/fetch_unit.sv
src/decode_stage.sv
src/execute_stage.sv
src/mem_sequencer.sv
src/core.sv
verification/core_checker.sv
verification/core_tb.sv

// File: src/alu.sv
`default_nettype none
`timescale 1ns/10ps

module alu
(
    input  core_cfg_pkg::data_t op_a,
    input  core_cfg_pkg::data_t op_b,
    input  isa_pkg::alu_op_t alu_op,
    output core_cfg_pkg::data_t result,
    output logic equal,
    output logic less,
    output logic greater
);

import isa_pkg::*;

always_comb
begin
    case (alu_op)
        ALU_ADD:
            result = op_a + op_b;
        ALU_SUB, ALU_CMP:
            result = op_a - op_b;       // Compare result is never written
        ALU_AND:
            result = op_a & op_b;
        ALU_OR:
            result = op_a | op_b;
        ALU_XOR:
            result = op_a ^ op_b;
        ALU_NOT:
            result = ~op_a;
        ALU_NEG:
            result = -op_a;
        default:
            result = '0;
    endcase
end

// Unsigned compare of rd against rs
assign equal = (op_a == op_b);
assign less = (op_a < op_b);
assign greater = (op_a > op_b);

endmodule

`default_nettype wire

// File: src/core.sv
`default_nettype none
`timescale 1ns/10ps

module core
#(
    parameter int MEM_ADDR_WIDTH = core_cfg_pkg::MEM_ADDR_WIDTH_DEFAULT
)
(
    input  logic clk,
    input  logic rst,
    output logic [MEM_ADDR_WIDTH-1:0] mem_addr,
    output core_cfg_pkg::data_t mem_data_in,
    output logic mem_r_en,
    output logic mem_w_en,
    input  core_cfg_pkg::data_t mem_data_out,
    input  logic mem_rdy,
    input  logic mem_cplt,
    output core_cfg_pkg::reg_addr_t reg_r_addr_1,
    output core_cfg_pkg::reg_addr_t reg_r_addr_2,
    input  core_cfg_pkg::data_t reg_r_data_1,
    input  core_cfg_pkg::data_t reg_r_data_2,
    output core_cfg_pkg::reg_addr_t reg_w_addr,
    output core_cfg_pkg::data_t reg_w_data,
    output logic reg_w_en
);

import core_cfg_pkg::*;
import isa_pkg::*;

// Fetch side
logic [MEM_ADDR_WIDTH-1:0] pc, f_pc, redirect_addr;
instr_t f_instr;
logic f_valid, fetch_want, fetch_req, fetch_cplt, redirect, d_take;

// Decoded record
logic d_valid, d_reg_wr, d_mem_rd, d_mem_wr, d_jump, d_cond_en;
alu_op_t d_alu_op;
data_t d_op_a, d_op_b;
reg_addr_t d_rd;
branch_cond_t d_cond;
logic [MEM_ADDR_WIDTH-1:0] d_mem_addr, d_target;

// Execute and write-back record
logic x_take, x_wr;
reg_addr_t x_rd, w_rd;
logic w_valid, w_wr, w_mem_rd, w_mem_wr, w_branch, w_done;
data_t w_value;
logic [MEM_ADDR_WIDTH-1:0] w_mem_addr;

fetch_unit #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) fetch_inst (.*);

decode_stage #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) decode_inst (.*);

execute_stage #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) execute_inst (.*);

mem_sequencer #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) mem_seq_inst (.*);

endmodule

`default_nettype wire

// File: src/core_cfg_pkg.sv
`default_nettype none

package core_cfg_pkg;

parameter int DATA_WIDTH = 16;
parameter int REG_ADDR_WIDTH = 4;

typedef logic [DATA_WIDTH-1:0] data_t;
typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

// Core parameter default, overridable at the top
parameter int MEM_ADDR_WIDTH_DEFAULT = 16;

endpackage

`default_nettype wire

// File: src/decode_stage.sv
`default_nettype none
`timescale 1ns/10ps

module decode_stage
#(
    parameter int MEM_ADDR_WIDTH = core_cfg_pkg::MEM_ADDR_WIDTH_DEFAULT
)
(
    input  logic clk,
    input  logic rst,
    input  isa_pkg::instr_t f_instr,
    input  logic [MEM_ADDR_WIDTH-1:0] f_pc,
    input  logic f_valid,
    output logic d_take,
    output core_cfg_pkg::reg_addr_t reg_r_addr_1,
    output core_cfg_pkg::reg_addr_t reg_r_addr_2,
    input  core_cfg_pkg::data_t reg_r_data_1,
    input  core_cfg_pkg::data_t reg_r_data_2,
    input  logic x_take,
    input  logic redirect,
    input  core_cfg_pkg::reg_addr_t x_rd,
    input  logic x_wr,
    input  core_cfg_pkg::reg_addr_t w_rd,
    input  logic w_wr,
    output logic d_valid,
    output isa_pkg::alu_op_t d_alu_op,
    output core_cfg_pkg::data_t d_op_a,
    output core_cfg_pkg::data_t d_op_b,
    output core_cfg_pkg::reg_addr_t d_rd,
    output logic d_reg_wr,
    output logic d_mem_rd,
    output logic d_mem_wr,
    output logic [MEM_ADDR_WIDTH-1:0] d_mem_addr,
    output logic d_jump,
    output logic d_cond_en,
    output isa_pkg::branch_cond_t d_cond,
    output logic [MEM_ADDR_WIDTH-1:0] d_target
);

import core_cfg_pkg::*;
import isa_pkg::*;

alu_op_t alu_op;
data_t op_a;
data_t op_b;
logic reg_wr;
logic mem_rd;
logic mem_wr;
logic jump;
logic cond_en;
logic uses_rs;
logic uses_rd;
logic stall;
logic signed [MEM_ADDR_WIDTH-1:0] br_off;
logic signed [MEM_ADDR_WIDTH-1:0] jmp_off;
logic [MEM_ADDR_WIDTH-1:0] target;

// Port 1 reads rs, port 2 reads rd
assign reg_r_addr_1 = f_instr.rop.rs;
assign reg_r_addr_2 = f_instr.rop.rd;

assign br_off = $signed(f_instr.br.offset);
assign jmp_off = $signed(f_instr.jmp.offset);
assign target = (f_instr.imm.opcode == OP_JMP) ? f_pc + jmp_off : f_pc + br_off;

always_comb
begin
    alu_op = ALU_ADD;
    op_a = '0;
    op_b = '0;
    reg_wr = 1'b0;
    mem_rd = 1'b0;
    mem_wr = 1'b0;
    jump = 1'b0;
    cond_en = 1'b0;
    uses_rs = 1'b0;
    uses_rd = 1'b0;
    case (f_instr.imm.opcode)
        OP_LD:
        begin
            reg_wr = 1'b1;
            mem_rd = 1'b1;
        end
        OP_JMP:
            jump = 1'b1;
        OP_ST:
        begin
            op_b = reg_r_data_2;        // Store data passes the ALU
            mem_wr = 1'b1;
            uses_rd = 1'b1;
        end
        OP_LI:
        begin
            // Replace one byte, keep the other
            if (f_instr.lim.high)
                op_b = {f_instr.lim.value, reg_r_data_2[7:0]};
            else
                op_b = {reg_r_data_2[DATA_WIDTH-1:8], f_instr.lim.value};
            reg_wr = 1'b1;
            uses_rd = 1'b1;
        end
        OP_BR:
            cond_en = 1'b1;
        OP_ADDI, OP_SUBI:
        begin
            alu_op = (f_instr.imm.opcode == OP_SUBI) ? ALU_SUB : ALU_ADD;
            op_a = reg_r_data_2;
            op_b = DATA_WIDTH'(f_instr.imm.value);
            reg_wr = 1'b1;
            uses_rd = 1'b1;
        end
        default:
        begin
            // Group 1 is not implemented
            if (!f_instr.rop.group)
            begin
                alu_op = f_instr.rop.func;
                op_a = reg_r_data_2;
                op_b = reg_r_data_1;
                reg_wr = (f_instr.rop.func != ALU_CMP);
                uses_rd = 1'b1;
                uses_rs = (f_instr.rop.func != ALU_NOT) && (f_instr.rop.func != ALU_NEG);
            end
        end
    endcase
end

// Wait until older writes to our sources have landed
assign stall = (uses_rs && ((x_wr && x_rd == reg_r_addr_1) || (w_wr && w_rd == reg_r_addr_1)))
            || (uses_rd && ((x_wr && x_rd == reg_r_addr_2) || (w_wr && w_rd == reg_r_addr_2)));

assign d_take = f_valid && !stall && (!d_valid || x_take) && !redirect;

always_ff @(posedge clk or posedge rst)
begin
    if (rst)
    begin
        d_valid <= 1'b0;
        d_reg_wr <= 1'b0;
        d_mem_rd <= 1'b0;
        d_mem_wr <= 1'b0;
        d_jump <= 1'b0;
        d_cond_en <= 1'b0;
    end
    else if (redirect)
        d_valid <= 1'b0;
    else if (d_take)
    begin
        d_valid <= 1'b1;
        d_reg_wr <= reg_wr;
        d_mem_rd <= mem_rd;
        d_mem_wr <= mem_wr;
        d_jump <= jump;
        d_cond_en <= cond_en;
    end
    else if (x_take)
        d_valid <= 1'b0;
end

always_ff @(posedge clk)
begin
    if (d_take)
    begin
        d_alu_op <= alu_op;
        d_op_a <= op_a;
        d_op_b <= op_b;
        d_rd <= f_instr.imm.rd;
        d_mem_addr <= MEM_ADDR_WIDTH'(f_instr.imm.value);
        d_cond <= f_instr.br.cond;
        d_target <= target;
    end
end

endmodule

`default_nettype wire

// File: src/execute_stage.sv
`default_nettype none
`timescale 1ns/10ps

module execute_stage
#(
    parameter int MEM_ADDR_WIDTH = core_cfg_pkg::MEM_ADDR_WIDTH_DEFAULT
)
(
    input  logic clk,
    input  logic rst,
    input  logic d_valid,
    input  isa_pkg::alu_op_t d_alu_op,
    input  core_cfg_pkg::data_t d_op_a,
    input  core_cfg_pkg::data_t d_op_b,
    input  core_cfg_pkg::reg_addr_t d_rd,
    input  logic d_reg_wr,
    input  logic d_mem_rd,
    input  logic d_mem_wr,
    input  logic [MEM_ADDR_WIDTH-1:0] d_mem_addr,
    input  logic d_jump,
    input  logic d_cond_en,
    input  isa_pkg::branch_cond_t d_cond,
    input  logic [MEM_ADDR_WIDTH-1:0] d_target,
    output logic x_take,
    input  logic redirect,
    input  logic w_done,
    output core_cfg_pkg::reg_addr_t x_rd,
    output logic x_wr,
    output logic w_valid,
    output core_cfg_pkg::reg_addr_t w_rd,
    output logic w_wr,
    output core_cfg_pkg::data_t w_value,
    output logic w_mem_rd,
    output logic w_mem_wr,
    output logic [MEM_ADDR_WIDTH-1:0] w_mem_addr,
    output logic w_branch
);

import core_cfg_pkg::*;
import isa_pkg::*;

data_t result;
logic equal;
logic less;
logic greater;
logic flag_eq;
logic flag_lt;
logic flag_gt;
logic cond_met;
logic taken;

alu alu_inst
(
    .op_a(d_op_a),
    .op_b(d_op_b),
    .alu_op(d_alu_op),
    .result(result),
    .equal(equal),
    .less(less),
    .greater(greater)
);

assign x_take = d_valid && (!w_valid || w_done) && !redirect;

// Pending write seen by the decode hazard check
assign x_rd = d_rd;
assign x_wr = d_valid && d_reg_wr;

always_comb
begin
    case (d_cond)
        BR_EQ:   cond_met = flag_eq;
        BR_NE:   cond_met = !flag_eq;
        BR_LT:   cond_met = flag_lt;
        default: cond_met = flag_gt;
    endcase
end

assign taken = d_jump || (d_cond_en && cond_met);

always_ff @(posedge clk or posedge rst)
begin
    if (rst)
    begin
        flag_eq <= 1'b0;
        flag_lt <= 1'b0;
        flag_gt <= 1'b0;
    end
    else if (x_take && d_alu_op == ALU_CMP)
    begin
        flag_eq <= equal;
        flag_lt <= less;
        flag_gt <= greater;
    end
end

always_ff @(posedge clk or posedge rst)
begin
    if (rst)
    begin
        w_valid <= 1'b0;
        w_wr <= 1'b0;
        w_mem_rd <= 1'b0;
        w_mem_wr <= 1'b0;
        w_branch <= 1'b0;
    end
    else if (x_take)
    begin
        w_valid <= 1'b1;
        w_wr <= d_reg_wr;
        w_mem_rd <= d_mem_rd;
        w_mem_wr <= d_mem_wr;
        w_branch <= taken;
    end
    else if (w_done)
    begin
        // Retired, so no write stays pending
        w_valid <= 1'b0;
        w_wr <= 1'b0;
        w_mem_rd <= 1'b0;
        w_mem_wr <= 1'b0;
        w_branch <= 1'b0;
    end
end

always_ff @(posedge clk)
begin
    if (x_take)
    begin
        w_rd <= d_rd;
        w_value <= result;
        w_mem_addr <= taken ? d_target : d_mem_addr;   // Target rides in the address
    end
end

endmodule

`default_nettype wire

// File: src/fetch_unit.sv
`default_nettype none
`timescale 1ns/10ps

module fetch_unit
#(
    parameter int MEM_ADDR_WIDTH = core_cfg_pkg::MEM_ADDR_WIDTH_DEFAULT
)
(
    input  logic clk,
    input  logic rst,
    input  logic fetch_req,
    input  logic fetch_cplt,
    input  core_cfg_pkg::data_t mem_data_out,
    input  logic redirect,
    input  logic [MEM_ADDR_WIDTH-1:0] redirect_addr,
    input  logic d_take,
    output logic [MEM_ADDR_WIDTH-1:0] pc,
    output isa_pkg::instr_t f_instr,
    output logic [MEM_ADDR_WIDTH-1:0] f_pc,
    output logic f_valid,
    output logic fetch_want
);

logic pending;                          // Fetch accepted, word not back yet
logic [MEM_ADDR_WIDTH-1:0] req_pc;      // Address of the fetch in flight

// Buffer is free or emptying this cycle
assign fetch_want = !pending && (!f_valid || d_take);

always_ff @(posedge clk or posedge rst)
begin
    if (rst)
    begin
        pc <= '0;
        pending <= 1'b0;
        f_valid <= 1'b0;
    end
    else
    begin
        if (redirect)
            pc <= redirect_addr;
        else if (fetch_req)
            pc <= pc + 1'b1;

        if (redirect || fetch_cplt)
            pending <= 1'b0;
        else if (fetch_req)
            pending <= 1'b1;

        if (redirect)
            f_valid <= 1'b0;            // Redirect beats a fill
        else if (fetch_cplt)
            f_valid <= 1'b1;
        else if (d_take)
            f_valid <= 1'b0;
    end
end

always_ff @(posedge clk)
begin
    if (fetch_req)
        req_pc <= pc;
    if (fetch_cplt)
    begin
        f_instr <= mem_data_out;
        f_pc <= req_pc;
    end
end

endmodule

`default_nettype wire

// File: src/isa_pkg.sv
`default_nettype none

package isa_pkg;

typedef enum logic [2:0] {
    OP_LD   = 3'b000,
    OP_JMP  = 3'b001,
    OP_ST   = 3'b010,
    OP_LI   = 3'b011,
    OP_BR   = 3'b100,
    OP_ADDI = 3'b101,
    OP_SUBI = 3'b110,
    OP_REG  = 3'b111
} opcode_t;

// Gaps in the encoding are unused functions
typedef enum logic [3:0] {
    ALU_ADD = 4'b0000,
    ALU_SUB = 4'b0001,
    ALU_AND = 4'b0011,
    ALU_OR  = 4'b0100,
    ALU_XOR = 4'b0101,
    ALU_NOT = 4'b0110,
    ALU_NEG = 4'b0111,
    ALU_CMP = 4'b1000
} alu_op_t;

typedef enum logic [1:0] {
    BR_EQ = 2'b00,
    BR_NE = 2'b01,
    BR_LT = 2'b10,
    BR_GT = 2'b11
} branch_cond_t;

typedef struct packed {
    opcode_t opcode;
    logic [8:0] value;          // Address or immediate
    core_cfg_pkg::reg_addr_t rd;
} imm_fmt_t;

typedef struct packed {
    opcode_t opcode;
    logic high;                 // Set for the upper byte
    logic [7:0] value;
    core_cfg_pkg::reg_addr_t rd;
} lim_fmt_t;

typedef struct packed {
    opcode_t opcode;
    logic group;
    alu_op_t func;
    core_cfg_pkg::reg_addr_t rs;
    core_cfg_pkg::reg_addr_t rd;
} rop_fmt_t;

typedef struct packed {
    opcode_t opcode;
    branch_cond_t cond;
    logic [10:0] offset;
} br_fmt_t;

typedef struct packed {
    opcode_t opcode;
    logic [12:0] offset;
} jmp_fmt_t;

typedef union packed {
    imm_fmt_t imm;
    lim_fmt_t lim;
    rop_fmt_t rop;
    br_fmt_t br;
    jmp_fmt_t jmp;
} instr_t;

endpackage

`default_nettype wire

// File: src/mem_sequencer.sv
`default_nettype none
`timescale 1ns/10ps

module mem_sequencer
#(
    parameter int MEM_ADDR_WIDTH = core_cfg_pkg::MEM_ADDR_WIDTH_DEFAULT
)
(
    input  logic clk,
    input  logic rst,
    input  logic w_valid,
    input  core_cfg_pkg::reg_addr_t w_rd,
    input  logic w_wr,
    input  core_cfg_pkg::data_t w_value,
    input  logic w_mem_rd,
    input  logic w_mem_wr,
    input  logic [MEM_ADDR_WIDTH-1:0] w_mem_addr,
    input  logic w_branch,
    output logic w_done,
    input  logic fetch_want,
    input  logic [MEM_ADDR_WIDTH-1:0] pc,
    output logic fetch_req,
    output logic fetch_cplt,
    output logic redirect,
    output logic [MEM_ADDR_WIDTH-1:0] redirect_addr,
    output logic [MEM_ADDR_WIDTH-1:0] mem_addr,
    output core_cfg_pkg::data_t mem_data_in,
    output logic mem_r_en,
    output logic mem_w_en,
    input  core_cfg_pkg::data_t mem_data_out,
    input  logic mem_rdy,
    input  logic mem_cplt,
    output core_cfg_pkg::reg_addr_t reg_w_addr,
    output core_cfg_pkg::data_t reg_w_data,
    output logic reg_w_en
);

typedef enum logic [1:0] {IDLE, FETCH, DATA} state_t;

state_t state;
logic issued;                           // Strobe seen with mem_rdy, waiting for mem_cplt
logic discard;                          // Fetch in flight went stale on a redirect
logic data_pend;
logic access_done;
logic [MEM_ADDR_WIDTH-1:0] addr_q;

assign data_pend = w_valid && (w_mem_rd || w_mem_wr);
assign access_done = issued && mem_cplt;

assign redirect = w_valid && w_branch;
assign redirect_addr = w_mem_addr;

// Data access wins over a fetch
assign fetch_req = (state == IDLE) && !data_pend && fetch_want && !redirect;
assign fetch_cplt = (state == FETCH) && access_done && !discard;

assign w_done = data_pend ? ((state == DATA) && access_done) : w_valid;

assign mem_addr = addr_q;
assign mem_data_in = w_value;
assign mem_r_en = !issued && ((state == FETCH) || ((state == DATA) && w_mem_rd));
assign mem_w_en = !issued && (state == DATA) && w_mem_wr;

assign reg_w_addr = w_rd;
assign reg_w_data = w_mem_rd ? mem_data_out : w_value;
assign reg_w_en = w_done && w_wr;

always_ff @(posedge clk or posedge rst)
begin
    if (rst)
    begin
        state <= IDLE;
        issued <= 1'b0;
        discard <= 1'b0;
    end
    else if (state == IDLE)
    begin
        if (data_pend)
            state <= DATA;
        else if (fetch_req)
            state <= FETCH;
    end
    else if (access_done)
    begin
        state <= IDLE;
        issued <= 1'b0;
        discard <= 1'b0;
    end
    else
    begin
        if (mem_rdy)
            issued <= 1'b1;
        if (redirect && state == FETCH)
            discard <= 1'b1;
    end
end

// Address is frozen once the access leaves idle
always_ff @(posedge clk)
begin
    if (state == IDLE)
        addr_q <= data_pend ? w_mem_addr : pc;
end

endmodule

`default_nettype wire

// File: verification/core_cases.txt
// Case header: id, cycle budget, program word count, check count (all hex)
// Then program words from address 0, then checks: kind (0 register, 1 memory), index, expected
0001 0400 0012 0008     // Immediates and register ALU operations
6341 7121 60F2 B002 C0F2 6F03 E013 6FF4 E314
7F05 E415 E535 E121 6056 E606 6037 E707 2000
0000 0001 1134  0000 0002 0100  0000 0003 1324  0000 0004 0034
0000 0005 E110  0000 0006 FFFA  0000 0007 FFFD  0000 0000 0000
0002 0300 000A 0006     // Load and store direct, data word at address 9
6AB1 7CD1 4801 0802 A012 4812 0093 4823 2000 5A5A
0000 0001 CDAB  0000 0002 CDAC  0000 0003 5A5A
0001 0080 CDAB  0001 0081 CDAC  0001 0082 5A5A
0003 0300 000A 0004     // Back-to-back dependent instructions
6011 A021 E011 E012 BFF2 E121 4881 0883 C013 2000
0000 0001 FE01  0000 0002 0205  0000 0003 FE00  0001 0088 FE01
0004 0400 0017 0006     // Branch conditions after compare, forward and backward jumps
6051 6092 E821 9002 6EE3 8002 A014 9802
A024 8802 A105 E812 9802 A205 E811 8003
A405 2000 2003 A805 2000 A076 3FFE
0000 0001 0005  0000 0002 0009  0000 0003 0000
0000 0004 0003  0000 0005 0000  0000 0006 0007
0000                    // End of cases

// File: verification/core_checker.sv
`default_nettype none
`timescale 1ns/10ps

module core_checker
#(
    parameter int ADDR_WIDTH = core_cfg_pkg::MEM_ADDR_WIDTH_DEFAULT
)
(
    input  logic clk,
    input  logic rst,
    input  logic [ADDR_WIDTH-1:0] mem_addr,
    input  core_cfg_pkg::data_t mem_data_in,
    input  logic mem_r_en,
    input  logic mem_w_en,
    input  logic mem_rdy,
    input  logic mem_cplt,
    input  logic reg_w_en
);

logic strobe;
logic outstanding;          // Accepted access still waiting for mem_cplt

assign strobe = mem_r_en || mem_w_en;

always_ff @(posedge clk or posedge rst)
begin
    if (rst)
        outstanding <= 1'b0;
    else if (mem_cplt)
        outstanding <= 1'b0;
    else if (strobe && mem_rdy)
        outstanding <= 1'b1;
end

exclusive_strobes: assert property (@(posedge clk) !(mem_r_en && mem_w_en))
    else $error("mem_r_en and mem_w_en are high in the same cycle");

quiet_in_reset: assert property (@(posedge clk) rst |-> !strobe && !reg_w_en)
    else $error("A memory or register strobe is high during reset");

// Request must not change until the memory takes it
request_held: assert property (@(posedge clk) disable iff (rst)
    strobe && !mem_rdy |=> $stable(mem_addr) && $stable(mem_r_en) && $stable(mem_w_en)
        && (!mem_w_en || $stable(mem_data_in)))
    else $error("Memory request changed while waiting for mem_rdy");

single_outstanding: assert property (@(posedge clk) disable iff (rst) outstanding |-> !strobe)
    else $error("New memory strobe raised before mem_cplt of the previous access");

endmodule

bind core core_checker #(.ADDR_WIDTH(MEM_ADDR_WIDTH)) core_checker_inst (.*);

`default_nettype wire

// File: verification/core_tb.sv
`default_nettype none
`timescale 1ns/10ps

module core_tb;

import core_cfg_pkg::*;

localparam int CLK_PERIOD = 100;
localparam int DRIVE_DELAY = 1;
localparam int RESET_CYCLES = 8;
localparam int MEM_WORDS = 256;
localparam int REG_COUNT = 1 << REG_ADDR_WIDTH;
localparam int CASE_WORDS = 1024;
localparam int WATCHDOG_MARGIN = 200;
localparam logic [31:0] SEED = 32'h24eb_b4f5;

logic clk;
logic rst;
logic [MEM_ADDR_WIDTH_DEFAULT-1:0] mem_addr;
data_t mem_data_in;
logic mem_r_en;
logic mem_w_en;
data_t mem_data_out;
logic mem_rdy;
logic mem_cplt;
reg_addr_t reg_r_addr_1;
reg_addr_t reg_r_addr_2;
data_t reg_r_data_1;
data_t reg_r_data_2;
reg_addr_t reg_w_addr;
data_t reg_w_data;
logic reg_w_en;

data_t mem_words [MEM_WORDS];
data_t image [MEM_WORDS];           // Program image, copied in during reset
data_t regs [REG_COUNT];
logic [15:0] case_words [CASE_WORDS];

logic busy;
logic raise;
int wait_cnt;
logic [7:0] acc_addr;
int watchdog_cycles;
int cases_run;

core core_inst
(
    .clk(clk),
    .rst(rst),
    .mem_addr(mem_addr),
    .mem_data_in(mem_data_in),
    .mem_r_en(mem_r_en),
    .mem_w_en(mem_w_en),
    .mem_data_out(mem_data_out),
    .mem_rdy(mem_rdy),
    .mem_cplt(mem_cplt),
    .reg_r_addr_1(reg_r_addr_1),
    .reg_r_addr_2(reg_r_addr_2),
    .reg_r_data_1(reg_r_data_1),
    .reg_r_data_2(reg_r_data_2),
    .reg_w_addr(reg_w_addr),
    .reg_w_data(reg_w_data),
    .reg_w_en(reg_w_en)
);

always #(CLK_PERIOD / 2) clk = ~clk;

assign reg_r_data_1 = regs[reg_r_addr_1];
assign reg_r_data_2 = regs[reg_r_addr_2];

always @(posedge clk)
begin
    if (rst)
    begin
        for (int i = 0; i < REG_COUNT; i++)
            regs[i] <= '0;
    end
    else if (reg_w_en)
        regs[reg_w_addr] <= reg_w_data;
end

// Memory with random ready and 1 to 3 cycles to completion
initial
begin
    void'($urandom(SEED));
    forever
    begin
        @(posedge clk);
        raise = 1'b0;
        if (rst)
        begin
            for (int i = 0; i < MEM_WORDS; i++)
                mem_words[i] = image[i];
            busy = 1'b0;
            wait_cnt = 0;
        end
        else if (mem_cplt)
            busy = 1'b0;
        else if (busy)
        begin
            wait_cnt = wait_cnt - 1;
            raise = (wait_cnt == 0);
        end
        else if (mem_rdy && (mem_r_en || mem_w_en))
        begin
            busy = 1'b1;
            acc_addr = mem_addr[7:0];
            if (mem_w_en)
                mem_words[acc_addr] = mem_data_in;
            wait_cnt = $urandom_range(3, 1) - 1;
            raise = (wait_cnt == 0);
        end
        #(DRIVE_DELAY);
        mem_cplt = raise;
        mem_data_out = raise ? mem_words[acc_addr] : '0;
        mem_rdy = rst ? 1'b0 : (($urandom % 4) != 0);
    end
end

function automatic string case_label(input int id);
    case (id)
        1: return "alu_ops";
        2: return "load_store";
        3: return "hazard_chain";
        4: return "branches";
        default: return "unnamed_case";
    endcase
endfunction

// Budgets plus reset time of every case
function automatic int total_cycles();
    int pos;
    int total;

    pos = 0;
    total = WATCHDOG_MARGIN;
    while (pos < CASE_WORDS - 4 && case_words[pos] != 16'h0000)
    begin
        total = total + case_words[pos + 1] + RESET_CYCLES + 2;
        pos = pos + 4 + case_words[pos + 2] + 3 * case_words[pos + 3];
    end
    return total;
endfunction

task automatic stop_with_failure();
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped after a failure");
endtask

initial
begin
    int pos;
    int case_id;
    int budget;
    int nprog;
    int nchk;
    int kind;
    int index;
    data_t expected;
    data_t actual;

    clk = 1'b0;
    rst = 1'b1;
    mem_rdy = 1'b0;
    mem_cplt = 1'b0;
    mem_data_out = '0;
    cases_run = 0;
    for (int i = 0; i < CASE_WORDS; i++)
        case_words[i] = '0;
    $readmemh("verification/core_cases.txt", case_words);
    watchdog_cycles = total_cycles();

    pos = 0;
    while (pos < CASE_WORDS - 4 && case_words[pos] != 16'h0000)
    begin
        case_id = case_words[pos];
        budget = case_words[pos + 1];
        nprog = case_words[pos + 2];
        nchk = case_words[pos + 3];
        pos = pos + 4;
        for (int i = 0; i < MEM_WORDS; i++)
            image[i] = '0;
        for (int i = 0; i < nprog; i++)
            image[i] = case_words[pos + i];
        pos = pos + nprog;

        @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;
        repeat (budget) @(posedge clk);
        @(negedge clk);                 // Models settled

        for (int c = 0; c < nchk; c++)
        begin
            kind = case_words[pos];
            index = case_words[pos + 1];
            expected = case_words[pos + 2];
            pos = pos + 3;
            actual = (kind == 0) ? regs[index] : mem_words[index];
            assert (actual === expected)
            else
            begin
                $display("Error: %s %s %0h: expected %h, actual %h", case_label(case_id),
                         (kind == 0) ? "register" : "memory word", index, expected, actual);
                stop_with_failure();
            end
        end
        cases_run++;
    end

    if (cases_run > 0)
    begin
        $display("STATUS: PASS");
        $finish;
    end
    else
    begin
        $display("No test cases were read from verification/core_cases.txt");
        stop_with_failure();
    end
end

initial
begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the test run did not finish", watchdog_cycles);
    stop_with_failure();
end

endmodule

`default_nettype wire
